// ==== hdl/tcdm_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM subsystem sizes, index widths and channel payload types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package tcdm_pkg;

  // Port counts
  localparam int unsigned NUM_INI  = 4;  // Initiator ports
  localparam int unsigned NUM_BANK = 4;  // Word-interleaved banks

  // Initiator side widths
  localparam int unsigned ADDR_W     = 32;  // Byte address
  localparam int unsigned DATA_W     = 32;  // Data word
  localparam int unsigned BE_W       = 4;   // One enable per byte
  localparam int unsigned BYTE_OFF_W = 2;   // Byte offset within a word

  // Address split, bank select sits right above the byte offset
  localparam int unsigned BANK_IDX_W  = 2;
  localparam int unsigned BANK_ADDR_W = 6;  // 64 words per bank
  localparam int unsigned INI_IDX_W   = 2;  // Travels with each request

  // Pending responses per bank
  localparam int unsigned BANK_QUEUE_DEPTH = 2;

  // Request payload as seen by a bank
  typedef struct packed {
    logic                   wen;    // Write enable
    logic [BE_W-1:0]        be;     // Byte enables
    logic [BANK_ADDR_W-1:0] addr;   // Word address inside the bank
    logic [DATA_W-1:0]      wdata;  // Write data
  } tcdm_req_t;

  // Response payload
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } tcdm_resp_t;

endpackage

// ==== hdl/tcdm_bank_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One bank's request and response channels, valid/ready on both
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface tcdm_bank_if;

  // Request channel
  logic                               req_valid;
  logic                               req_ready;
  logic [tcdm_pkg::INI_IDX_W-1:0]     req_ini;    // Originating initiator
  tcdm_pkg::tcdm_req_t                req;

  // Response channel
  logic                               resp_valid;
  logic                               resp_ready;
  logic [tcdm_pkg::INI_IDX_W-1:0]     resp_ini;   // Routes the response back
  tcdm_pkg::tcdm_resp_t               resp;

  // Interconnect side
  modport xbar (
    output req_valid, req_ini, req, resp_ready,
    input  req_ready, resp_valid, resp_ini, resp
  );

  // Memory side
  modport bank (
    input  req_valid, req_ini, req, resp_ready,
    output req_ready, resp_valid, resp_ini, resp
  );

endinterface

// ==== hdl/rr_arbiter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter with payload mux and winner index
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rr_arbiter #(
  parameter type         payload_t = logic,  // Routed payload
  parameter int unsigned NumInp    = 4       // Competing inputs
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // Input side
  input  logic     [NumInp-1:0]      valid_i,
  input  payload_t [NumInp-1:0]      data_i,
  output logic     [NumInp-1:0]      ready_o,   // Grant AND downstream ready
  // Output side
  output logic                       valid_o,
  output payload_t                   data_o,
  output logic [$clog2(NumInp)-1:0]  idx_o,     // Winning input
  input  logic                       ready_i
);

  logic [$clog2(NumInp)-1:0] rr_q;  // Highest priority input
  logic [$clog2(NumInp)-1:0] rr_d;

  // Search starts at the pointer and wraps around
  always_comb begin : find_winner
    int unsigned cand;
    valid_o = 1'b0;
    idx_o   = '0;
    for (int unsigned i = 0; i < NumInp; i++) begin
      cand = (32'(rr_q) + i) % NumInp;
      if (!valid_o && valid_i[cand]) begin
        valid_o = 1'b1;
        idx_o   = cand[$clog2(NumInp)-1:0];
      end
    end
  end

  assign data_o = data_i[idx_o];  // Payload of the winner

  always_comb begin
    ready_o        = '0;
    ready_o[idx_o] = valid_o & ready_i;  // Only the winner sees ready
  end

  // Next pointer is one past the winner
  always_comb begin : next_ptr
    int unsigned nxt;
    nxt  = (32'(idx_o) + 1) % NumInp;
    rr_d = nxt[$clog2(NumInp)-1:0];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q <= '0;
    end else if (valid_o && ready_i) begin
      rr_q <= rr_d;  // Move on completed transfer only
    end
  end

  // A waiting input is served before the last winner gets another turn
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && ready_i |=> (idx_o != $past(idx_o)) ||
      ((valid_i & $past(valid_i & ~ready_o)) == '0))
    else $error("rr_arbiter: winner granted again while another input waited");

endmodule

// ==== hdl/full_duplex_xbar.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational request and response crossbars between initiators
// and banks, one round-robin arbiter per output port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module full_duplex_xbar (
  input  logic                                                    clk_i,
  input  logic                                                    arst_n_i,
  // Initiator requests
  input  logic [tcdm_pkg::NUM_INI-1:0]                            ini_req_valid_i,
  input  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::BANK_IDX_W-1:0]  ini_req_bank_i,
  input  tcdm_pkg::tcdm_req_t [tcdm_pkg::NUM_INI-1:0]             ini_req_i,
  output logic [tcdm_pkg::NUM_INI-1:0]                            ini_req_ready_o,
  // Initiator responses
  output logic [tcdm_pkg::NUM_INI-1:0]                            ini_resp_valid_o,
  output tcdm_pkg::tcdm_resp_t [tcdm_pkg::NUM_INI-1:0]            ini_resp_o,
  input  logic [tcdm_pkg::NUM_INI-1:0]                            ini_resp_ready_i,
  // Bank requests
  output logic [tcdm_pkg::NUM_BANK-1:0]                           bank_req_valid_o,
  output logic [tcdm_pkg::NUM_BANK-1:0][tcdm_pkg::INI_IDX_W-1:0]  bank_req_ini_o,
  output tcdm_pkg::tcdm_req_t [tcdm_pkg::NUM_BANK-1:0]            bank_req_o,
  input  logic [tcdm_pkg::NUM_BANK-1:0]                           bank_req_ready_i,
  // Bank responses
  input  logic [tcdm_pkg::NUM_BANK-1:0]                           bank_resp_valid_i,
  input  logic [tcdm_pkg::NUM_BANK-1:0][tcdm_pkg::INI_IDX_W-1:0]  bank_resp_ini_i,
  input  tcdm_pkg::tcdm_resp_t [tcdm_pkg::NUM_BANK-1:0]           bank_resp_i,
  output logic [tcdm_pkg::NUM_BANK-1:0]                           bank_resp_ready_o
);

  // Per bank, which initiators want it
  logic [tcdm_pkg::NUM_BANK-1:0][tcdm_pkg::NUM_INI-1:0] req_vld;
  logic [tcdm_pkg::NUM_BANK-1:0][tcdm_pkg::NUM_INI-1:0] req_gnt;
  // Per initiator, which banks answer it
  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::NUM_BANK-1:0] resp_vld;
  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::NUM_BANK-1:0] resp_gnt;

  // Address decode, bank index to one-hot valid
  always_comb begin
    for (int unsigned b = 0; b < tcdm_pkg::NUM_BANK; b++) begin
      for (int unsigned i = 0; i < tcdm_pkg::NUM_INI; i++) begin
        req_vld[b][i] = ini_req_valid_i[i] && (32'(ini_req_bank_i[i]) == b);
      end
    end
  end

  // Return path decode by initiator index
  always_comb begin
    for (int unsigned i = 0; i < tcdm_pkg::NUM_INI; i++) begin
      for (int unsigned b = 0; b < tcdm_pkg::NUM_BANK; b++) begin
        resp_vld[i][b] = bank_resp_valid_i[b] && (32'(bank_resp_ini_i[b]) == i);
      end
    end
  end

  // Each requester targets one bank, so OR-ing grants is enough
  always_comb begin
    ini_req_ready_o = '0;
    for (int unsigned b = 0; b < tcdm_pkg::NUM_BANK; b++) begin
      ini_req_ready_o |= req_gnt[b];
    end
  end

  always_comb begin
    bank_resp_ready_o = '0;
    for (int unsigned i = 0; i < tcdm_pkg::NUM_INI; i++) begin
      bank_resp_ready_o |= resp_gnt[i];  // Same for the response side
    end
  end

  for (genvar b = 0; b < tcdm_pkg::NUM_BANK; b++) begin : gen_req_arb
    rr_arbiter #(
      .payload_t (tcdm_pkg::tcdm_req_t),
      .NumInp    (tcdm_pkg::NUM_INI)
    ) i_req_arb (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (req_vld[b]),
      .data_i   (ini_req_i),
      .ready_o  (req_gnt[b]),
      .valid_o  (bank_req_valid_o[b]),
      .data_o   (bank_req_o[b]),
      .idx_o    (bank_req_ini_o[b]),   // Winner doubles as initiator index
      .ready_i  (bank_req_ready_i[b])
    );
  end

  for (genvar i = 0; i < tcdm_pkg::NUM_INI; i++) begin : gen_resp_arb
    rr_arbiter #(
      .payload_t (tcdm_pkg::tcdm_resp_t),
      .NumInp    (tcdm_pkg::NUM_BANK)
    ) i_resp_arb (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (resp_vld[i]),
      .data_i   (bank_resp_i),
      .ready_o  (resp_gnt[i]),
      .valid_o  (ini_resp_valid_o[i]),
      .data_o   (ini_resp_o[i]),
      .idx_o    (),                    // Source bank not needed upstream
      .ready_i  (ini_resp_ready_i[i])
    );
  end

endmodule

// ==== hdl/variable_latency_interconnect.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Variable-latency interconnect, address decode plus full crossbar
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module variable_latency_interconnect (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  // Initiator side
  input  logic [tcdm_pkg::NUM_INI-1:0]                       req_valid_i,
  input  logic [tcdm_pkg::NUM_INI-1:0]                       req_wen_i,
  input  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::DATA_W-1:0] req_wdata_i,
  input  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::BE_W-1:0]   req_be_i,
  output logic [tcdm_pkg::NUM_INI-1:0]                       req_ready_o,
  output logic [tcdm_pkg::NUM_INI-1:0]                       resp_valid_o,
  input  logic [tcdm_pkg::NUM_INI-1:0]                       resp_ready_i,
  output logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::DATA_W-1:0] resp_rdata_o,
  // Target side
  tcdm_bank_if.xbar                                          banks_o [tcdm_pkg::NUM_BANK]
);

  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::BANK_IDX_W-1:0]   bank_sel;
  tcdm_pkg::tcdm_req_t  [tcdm_pkg::NUM_INI-1:0]             req_agg;
  tcdm_pkg::tcdm_resp_t [tcdm_pkg::NUM_INI-1:0]             ini_resp;

  // Flattened target side of the crossbar
  logic [tcdm_pkg::NUM_BANK-1:0]                            bank_req_valid;
  logic [tcdm_pkg::NUM_BANK-1:0][tcdm_pkg::INI_IDX_W-1:0]   bank_req_ini;
  tcdm_pkg::tcdm_req_t  [tcdm_pkg::NUM_BANK-1:0]            bank_req;
  logic [tcdm_pkg::NUM_BANK-1:0]                            bank_req_ready;
  logic [tcdm_pkg::NUM_BANK-1:0]                            bank_resp_valid;
  logic [tcdm_pkg::NUM_BANK-1:0][tcdm_pkg::INI_IDX_W-1:0]   bank_resp_ini;
  tcdm_pkg::tcdm_resp_t [tcdm_pkg::NUM_BANK-1:0]            bank_resp;
  logic [tcdm_pkg::NUM_BANK-1:0]                            bank_resp_ready;

  for (genvar j = 0; j < tcdm_pkg::NUM_INI; j++) begin : gen_ini
    // Bank bits sit just above the byte offset, row bits above those
    assign bank_sel[j]      = req_addr_i[j][tcdm_pkg::BYTE_OFF_W +: tcdm_pkg::BANK_IDX_W];
    assign req_agg[j].wen   = req_wen_i[j];
    assign req_agg[j].be    = req_be_i[j];
    assign req_agg[j].addr  =
      req_addr_i[j][tcdm_pkg::BYTE_OFF_W + tcdm_pkg::BANK_IDX_W +: tcdm_pkg::BANK_ADDR_W];
    assign req_agg[j].wdata = req_wdata_i[j];
    assign resp_rdata_o[j]  = ini_resp[j].rdata;

    // Stalled request keeps its payload until taken
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req_valid_i[j] && !req_ready_o[j] |=> req_valid_i[j] &&
        $stable({req_wen_i[j], req_be_i[j], req_addr_i[j], req_wdata_i[j]}))
      else $error("interconnect: initiator %0d changed a stalled request", j);
  end

  // Bank interfaces onto flat vectors
  for (genvar k = 0; k < tcdm_pkg::NUM_BANK; k++) begin : gen_bank
    assign banks_o[k].req_valid  = bank_req_valid[k];
    assign banks_o[k].req_ini    = bank_req_ini[k];
    assign banks_o[k].req        = bank_req[k];
    assign bank_req_ready[k]     = banks_o[k].req_ready;
    assign bank_resp_valid[k]    = banks_o[k].resp_valid;
    assign bank_resp_ini[k]      = banks_o[k].resp_ini;
    assign bank_resp[k]          = banks_o[k].resp;
    assign banks_o[k].resp_ready = bank_resp_ready[k];
  end

  full_duplex_xbar i_xbar (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .ini_req_valid_i   (req_valid_i),
    .ini_req_bank_i    (bank_sel),
    .ini_req_i         (req_agg),
    .ini_req_ready_o   (req_ready_o),
    .ini_resp_valid_o  (resp_valid_o),
    .ini_resp_o        (ini_resp),
    .ini_resp_ready_i  (resp_ready_i),
    .bank_req_valid_o  (bank_req_valid),
    .bank_req_ini_o    (bank_req_ini),
    .bank_req_o        (bank_req),
    .bank_req_ready_i  (bank_req_ready),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_ini_i   (bank_resp_ini),
    .bank_resp_i       (bank_resp),
    .bank_resp_ready_o (bank_resp_ready)
  );

endmodule

// ==== hdl/tcdm_bank.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory bank with byte-enable writes and a pending response queue
// answering 1 to 3 cycles after acceptance, in order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tcdm_bank (
  input  logic      clk_i,
  input  logic      arst_n_i,
  tcdm_bank_if.bank bank_io
);

  logic [tcdm_pkg::DATA_W-1:0]    mem_q   [2**tcdm_pkg::BANK_ADDR_W];
  // Pending queue entries
  logic [tcdm_pkg::INI_IDX_W-1:0] ini_q   [tcdm_pkg::BANK_QUEUE_DEPTH];
  logic [tcdm_pkg::DATA_W-1:0]    rdata_q [tcdm_pkg::BANK_QUEUE_DEPTH];
  logic [1:0]                     dly_q   [tcdm_pkg::BANK_QUEUE_DEPTH];  // Cycles left

  logic [$clog2(tcdm_pkg::BANK_QUEUE_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(tcdm_pkg::BANK_QUEUE_DEPTH+1)-1:0] cnt_q;
  logic [7:0] lfsr_q;   // Latency source
  logic [1:0] lat;      // Latency minus one
  logic       push, pop;

  assign bank_io.req_ready  = 32'(cnt_q) != tcdm_pkg::BANK_QUEUE_DEPTH;  // Room left
  assign push               = bank_io.req_valid && bank_io.req_ready;
  assign bank_io.resp_valid = (cnt_q != '0) && (dly_q[rd_ptr_q] == 2'd0);  // Head expired
  assign bank_io.resp_ini   = ini_q[rd_ptr_q];
  assign bank_io.resp.rdata = rdata_q[rd_ptr_q];
  assign pop                = bank_io.resp_valid && bank_io.resp_ready;
  assign lat                = (lfsr_q[1:0] == 2'd3) ? 2'd1 : lfsr_q[1:0];  // Fold into 0..2

  // Word memory, written on acceptance
  always_ff @(posedge clk_i) begin
    if (push && bank_io.req.wen) begin
      for (int unsigned b = 0; b < tcdm_pkg::BE_W; b++) begin
        if (bank_io.req.be[b]) mem_q[bank_io.req.addr][8*b +: 8] <= bank_io.req.wdata[8*b +: 8];
      end
    end
  end

  // Entry payload, read data sampled before any write of this request
  always_ff @(posedge clk_i) begin
    for (int unsigned e = 0; e < tcdm_pkg::BANK_QUEUE_DEPTH; e++) begin
      if (dly_q[e] != 2'd0) dly_q[e] <= dly_q[e] - 2'd1;  // Count down
    end
    if (push) begin
      ini_q[wr_ptr_q]   <= bank_io.req_ini;
      rdata_q[wr_ptr_q] <= mem_q[bank_io.req.addr];
      dly_q[wr_ptr_q]   <= lat;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      lfsr_q   <= 8'hA5;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      if (push) wr_ptr_q <= (32'(wr_ptr_q) == tcdm_pkg::BANK_QUEUE_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (32'(rd_ptr_q) == tcdm_pkg::BANK_QUEUE_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Both or neither
      endcase
    end
  end

  // Stalled response holds until taken
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bank_io.resp_valid && !bank_io.resp_ready |=>
      bank_io.resp_valid && $stable(bank_io.resp) && $stable(bank_io.resp_ini))
    else $error("tcdm_bank: stalled response changed");

  // Count in range and in step with the pointers
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    32'(cnt_q) <= tcdm_pkg::BANK_QUEUE_DEPTH &&
      ((cnt_q == '0 || 32'(cnt_q) == tcdm_pkg::BANK_QUEUE_DEPTH) == (wr_ptr_q == rd_ptr_q)))
    else $error("tcdm_bank: pending queue overflow");

endmodule

// ==== hdl/tcdm_subsystem_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM subsystem, four initiators onto four interleaved banks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tcdm_subsystem_top (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  // Request channel per initiator
  input  logic [tcdm_pkg::NUM_INI-1:0]                       req_valid_i,
  input  logic [tcdm_pkg::NUM_INI-1:0]                       req_wen_i,
  input  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::DATA_W-1:0] req_wdata_i,
  input  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::BE_W-1:0]   req_be_i,
  output logic [tcdm_pkg::NUM_INI-1:0]                       req_ready_o,
  // Response channel per initiator
  output logic [tcdm_pkg::NUM_INI-1:0]                       resp_valid_o,
  input  logic [tcdm_pkg::NUM_INI-1:0]                       resp_ready_i,
  output logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::DATA_W-1:0] resp_rdata_o
);

  tcdm_bank_if bank_if [tcdm_pkg::NUM_BANK] ();  // One per bank

  variable_latency_interconnect i_interco (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_wen_i    (req_wen_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .banks_o      (bank_if)
  );

  // Word-interleaved banks
  for (genvar k = 0; k < tcdm_pkg::NUM_BANK; k++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .bank_io  (bank_if[k])
    );
  end

endmodule

// ==== dv/tb_tcdm_subsystem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the TCDM subsystem, random traffic on four initiators
// checked against a reference memory model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_tcdm_subsystem;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned SEED         = 19;
  localparam int unsigned TXN_PER_INI  = 150;
  localparam int unsigned NUM_TXN      = TXN_PER_INI * tcdm_pkg::NUM_INI;
  localparam int unsigned MAX_CYCLES   = 40 * NUM_TXN;  // Timeout
  localparam int unsigned DRAIN_CYCLES = 4;   // Longest bank latency plus one
  localparam int unsigned SAME_ROW_END = 16;  // Write then read back below this
  localparam int unsigned HOT_BANK_END = 48;  // All initiators on one bank below this
  localparam int unsigned WORD_IDX_W   = tcdm_pkg::BANK_IDX_W + tcdm_pkg::BANK_ADDR_W;
  localparam logic [tcdm_pkg::BANK_IDX_W-1:0] HOT_BANK = 2'd2;

  logic                                               clk_i;
  logic                                               arst_n_i;
  logic [tcdm_pkg::NUM_INI-1:0]                       req_valid_i;
  logic [tcdm_pkg::NUM_INI-1:0]                       req_wen_i;
  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::ADDR_W-1:0] req_addr_i;
  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::DATA_W-1:0] req_wdata_i;
  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::BE_W-1:0]   req_be_i;
  logic [tcdm_pkg::NUM_INI-1:0]                       req_ready_o;
  logic [tcdm_pkg::NUM_INI-1:0]                       resp_valid_o;
  logic [tcdm_pkg::NUM_INI-1:0]                       resp_ready_i;
  logic [tcdm_pkg::NUM_INI-1:0][tcdm_pkg::DATA_W-1:0] resp_rdata_o;

  // Reference model, word index is {row, bank}
  logic [tcdm_pkg::DATA_W-1:0] model_mem [2**WORD_IDX_W];
  logic                        written   [2**WORD_IDX_W];
  // Per initiator state
  int unsigned                 issued     [tcdm_pkg::NUM_INI];
  logic                        busy       [tcdm_pkg::NUM_INI];  // Request on the port
  logic                        pending    [tcdm_pkg::NUM_INI];  // Waiting for response
  logic                        exp_read   [tcdm_pkg::NUM_INI];
  logic [tcdm_pkg::DATA_W-1:0] exp_data   [tcdm_pkg::NUM_INI];
  logic [WORD_IDX_W-1:0]       last_word  [tcdm_pkg::NUM_INI];
  logic                        stalled    [tcdm_pkg::NUM_INI];  // Response held last cycle
  logic [tcdm_pkg::DATA_W-1:0] held_rdata [tcdm_pkg::NUM_INI];
  int unsigned                 req_cnt, resp_cnt, cycle;

  tcdm_subsystem_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  // Pick an owned row, then a bank and an access type by phase
  task automatic new_request(input int unsigned i);
    logic [tcdm_pkg::BANK_IDX_W-1:0]  bank;
    logic [tcdm_pkg::BANK_ADDR_W-1:0] row;
    logic [WORD_IDX_W-1:0]            word;
    logic                             wen;
    bank = 2'($urandom % tcdm_pkg::NUM_BANK);
    if (issued[i] >= SAME_ROW_END && issued[i] < HOT_BANK_END) bank = HOT_BANK;
    row  = 6'(($urandom % 16) * 4 + i);  // Row modulo 4 is the initiator
    word = {row, bank};
    wen  = 1'($urandom % 2);
    if (issued[i] < SAME_ROW_END) begin
      wen = (issued[i] % 2 == 0);  // Even steps write, odd steps read back
      if (!wen) word = last_word[i];
    end
    if (!written[word]) wen = 1'b1;  // Bank memory starts undefined
    req_wen_i[i]   = wen;
    req_addr_i[i]  = {22'd0, word, 2'b00};
    req_be_i[i]    = written[word] ? 4'($urandom) : 4'hF;  // First write fills the word
    req_wdata_i[i] = $urandom;
    req_valid_i[i] = 1'b1;
    last_word[i]   = word;
    busy[i]        = 1'b1;
    issued[i]++;
  endtask

  task automatic drive_inputs();
    for (int unsigned i = 0; i < tcdm_pkg::NUM_INI; i++) begin
      if (!busy[i]) begin
        req_valid_i[i] = 1'b0;
        if (!pending[i] && issued[i] < TXN_PER_INI && ($urandom % 100) < 60) new_request(i);
      end  // A busy port keeps its request unchanged
      resp_ready_i[i] = ($urandom % 100) < 70;  // Random back-pressure
    end
  endtask

  // Outputs are settled here, so these transfers happen at the next rising edge
  task automatic track_transfers();
    logic [WORD_IDX_W-1:0] w;
    for (int unsigned i = 0; i < tcdm_pkg::NUM_INI; i++) begin
      if (stalled[i]) begin
        assert (resp_valid_o[i]) else stop_on_error($sformatf(
          "error at time %0t: resp_valid_o[%0d] = 0, expected 1", $time, i));
        assert (resp_rdata_o[i] === held_rdata[i]) else stop_on_error($sformatf(
          "error at time %0t: resp_rdata_o[%0d] = %h, expected %h",
          $time, i, resp_rdata_o[i], held_rdata[i]));
      end
      stalled[i]    = resp_valid_o[i] && !resp_ready_i[i];
      held_rdata[i] = resp_rdata_o[i];
      if (resp_valid_o[i]) begin
        assert (pending[i]) else stop_on_error($sformatf(
          "initiator %0d got a response at time %0t without a request outstanding",
          i, $time));
        if (resp_ready_i[i]) begin
          if (exp_read[i]) begin
            assert (resp_rdata_o[i] === exp_data[i]) else stop_on_error($sformatf(
              "error at time %0t: resp_rdata_o[%0d] = %h, expected %h",
              $time, i, resp_rdata_o[i], exp_data[i]));
          end
          pending[i] = 1'b0;
          resp_cnt++;
        end
      end
      if (req_valid_i[i] && req_ready_o[i]) begin
        w = req_addr_i[i][tcdm_pkg::BYTE_OFF_W +: WORD_IDX_W];
        if (req_wen_i[i]) begin
          for (int unsigned b = 0; b < tcdm_pkg::BE_W; b++) begin
            if (req_be_i[i][b]) model_mem[w][8*b +: 8] = req_wdata_i[i][8*b +: 8];
          end
          written[w] = 1'b1;
        end
        exp_read[i] = !req_wen_i[i];
        exp_data[i] = model_mem[w];  // Word as seen at the transfer
        busy[i]     = 1'b0;
        pending[i]  = 1'b1;
        req_cnt++;
      end
    end
  endtask

  function automatic bit all_done();
    bit done;
    done = 1'b1;
    for (int unsigned i = 0; i < tcdm_pkg::NUM_INI; i++) begin
      if (issued[i] < TXN_PER_INI || busy[i] || pending[i]) done = 1'b0;
    end
    return done;
  endfunction

  initial begin
    void'($urandom(SEED));
    arst_n_i     = 1'b0;
    req_valid_i  = '0;
    req_wen_i    = '0;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    resp_ready_i = '0;
    req_cnt      = 0;
    resp_cnt     = 0;
    for (int unsigned w = 0; w < 2**WORD_IDX_W; w++) written[w] = 1'b0;
    for (int unsigned i = 0; i < tcdm_pkg::NUM_INI; i++) begin
      issued[i]  = 0;
      busy[i]    = 1'b0;
      pending[i] = 1'b0;
      stalled[i] = 1'b0;
    end

    // No response while in reset or right after it
    repeat (7) begin
      @(negedge clk_i);
      #(CLK_PERIOD/4);
      assert (resp_valid_o == '0) else stop_on_error($sformatf(
        "error at time %0t: resp_valid_o = %b during reset, expected 0", $time, resp_valid_o));
    end
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(posedge clk_i);  // First edge out of reset
    #(CLK_PERIOD/4);
    assert (resp_valid_o == '0) else stop_on_error($sformatf(
      "error at time %0t: resp_valid_o = %b after reset, expected 0", $time, resp_valid_o));

    cycle = 0;
    while (!all_done()) begin
      @(negedge clk_i);
      drive_inputs();
      #(CLK_PERIOD/4);
      track_transfers();
      cycle++;
      assert (cycle < MAX_CYCLES) else stop_on_error($sformatf(
        "timeout after %0d cycles with %0d requests and %0d responses done",
        cycle, req_cnt, resp_cnt));
    end

    // A second response to any request would show up here
    repeat (DRAIN_CYCLES) begin
      @(negedge clk_i);
      req_valid_i  = '0;
      resp_ready_i = '1;
      #(CLK_PERIOD/4);
      track_transfers();
    end

    if (req_cnt == NUM_TXN && resp_cnt == NUM_TXN) begin
      $display("No errors");
      $finish;
    end else begin
      stop_on_error($sformatf("run ended with %0d requests and %0d responses, expected %0d",
        req_cnt, resp_cnt, NUM_TXN));
    end
  end

endmodule

// ==== tcdm_subsystem.f ====
hdl/tcdm_pkg.sv
hdl/tcdm_bank_if.sv
hdl/rr_arbiter.sv
hdl/full_duplex_xbar.sv
hdl/variable_latency_interconnect.sv
hdl/tcdm_bank.sv
hdl/tcdm_subsystem_top.sv
dv/tb_tcdm_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the TCDM subsystem testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_tcdm_subsystem
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -Mdir "$OBJ_DIR" -f tcdm_subsystem.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
